// File: include/lb_settings.svh
/* Load balancer settings */

`ifndef LB_SETTINGS_SVH
`define LB_SETTINGS_SVH

// Cores and buffer slots per core
`define LB_CORE_COUNT 4
`define LB_SLOT_COUNT 4

// Stream word, one keep bit per byte
`define LB_DATA_WIDTH 64
`define LB_KEEP_WIDTH (`LB_DATA_WIDTH / 8)

// Host command port
`define LB_HOST_ADDR_WIDTH 8
`define LB_HOST_DATA_WIDTH 32

// Host register map
`define LB_ADDR_ENABLE     'h00
`define LB_ADDR_FLUSH      'h01
// Slot count of core i sits at base plus i
`define LB_ADDR_COUNT_BASE 'h04

`endif

// File: rtl/lb_slot_pkg.sv
/* Slot bookkeeping types */

package lb_slot_pkg;

  `include "lb_settings.svh"

  localparam int CORE_COUNT = `LB_CORE_COUNT;
  localparam int SLOT_COUNT = `LB_SLOT_COUNT;

  // Core and slot indices
  typedef logic [$clog2(CORE_COUNT)-1:0]   core_id_t;
  typedef logic [$clog2(SLOT_COUNT)-1:0]   slot_id_t;
  // Busy slots of one core, zero up to SLOT_COUNT
  typedef logic [$clog2(SLOT_COUNT+1)-1:0] slot_count_t;
  typedef logic [CORE_COUNT-1:0]           core_mask_t;
  // One busy bit per slot
  typedef logic [SLOT_COUNT-1:0]           slot_map_t;

  // Destination of a packet, one core and one of its slots
  typedef struct packed {
    core_id_t core;
    slot_id_t slot;
  } tag_t;

  // A returned slot names the same pair, core id taken from tuser
  typedef tag_t release_t;

  // Host command words
  typedef logic [`LB_HOST_ADDR_WIDTH-1:0] host_addr_t;
  typedef logic [`LB_HOST_DATA_WIDTH-1:0] host_word_t;

  localparam host_addr_t ADDR_ENABLE     = `LB_ADDR_ENABLE;
  localparam host_addr_t ADDR_FLUSH      = `LB_ADDR_FLUSH;
  localparam host_addr_t ADDR_COUNT_BASE = `LB_ADDR_COUNT_BASE;

endpackage

// File: rtl/lb_stream_pkg.sv
/* Packet stream types */

package lb_stream_pkg;

  `include "lb_settings.svh"

  import lb_slot_pkg::*;

  typedef logic [`LB_DATA_WIDTH-1:0] data_word_t;
  // Byte enables of one word
  typedef logic [`LB_KEEP_WIDTH-1:0] keep_t;

  // Plain beat, used on receive, return and transmit
  typedef struct packed {
    data_word_t data;
    keep_t      keep;
    logic       last;
  } tx_beat_t;

  // Beat toward the cores, tagged with its destination
  typedef struct packed {
    data_word_t data;
    keep_t      keep;
    logic       last;
    core_id_t   dest;
    slot_id_t   slot;
  } core_beat_t;

endpackage

// File: rtl/lb_sync_reset.sv
/* Reset synchronizer */

module lb_sync_reset (
  input  logic clk,
  input  logic rst,
  output logic rst_sync
);

  // Two flops, filled with ones while the external reset is high
  logic [1:0] rst_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      rst_q <= 2'b11;
    end else begin
      rst_q <= {rst_q[0], 1'b0};
    end
  end

  // Internal reset drops two cycles after the external one
  assign rst_sync = rst_q[1];

endmodule

// File: rtl/lb_boundary_reg.sv
/* Boundary register slice */

module lb_boundary_reg #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst,

  // Upstream side
  input  payload_t in_beat,
  input  logic     in_valid,
  output logic     in_ready,

  // Downstream side
  output payload_t out_beat,
  output logic     out_valid,
  input  logic     out_ready
);

  // Output entry and the skid entry behind it
  payload_t out_q;
  payload_t skid_q;
  logic     out_valid_q;
  logic     skid_valid_q;

  logic     out_free;
  logic     in_fire;

  // Output takes a new beat when empty or draining
  assign out_free = !out_valid_q || out_ready;
  assign in_fire  = in_valid && !skid_valid_q;

  // Ready comes straight from a flop, no path from out_ready
  assign in_ready  = !skid_valid_q;
  assign out_beat  = out_q;
  assign out_valid = out_valid_q;

  //////////////////////////////////////////////////////////////////////
  // Control

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid_q  <= 1'b0;
      skid_valid_q <= 1'b0;
    end else if (out_free) begin
      // Skid entry goes out first to keep order
      out_valid_q  <= skid_valid_q || in_valid;
      skid_valid_q <= 1'b0;
    end else if (in_fire) begin
      // Output held off, park the beat
      skid_valid_q <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Payload

  always_ff @(posedge clk) begin
    if (out_free) begin
      out_q <= skid_valid_q ? skid_q : in_beat;
    end
    if (in_fire && !out_free) begin
      skid_q <= in_beat;
    end
  end

endmodule

// File: rtl/lb_slot_ctrl.sv
/* Per-core slot controller */

module lb_slot_ctrl
  import lb_slot_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst,

  // Slot release stream from the cores
  input  slot_id_t                     rel_slot,
  input  core_id_t                     rel_core,
  input  logic                         rel_valid,
  output logic                         rel_ready,

  // Allocation for the policy
  input  core_id_t                     selected_core,
  input  logic                         desc_pop,
  output slot_id_t                     alloc_slot,
  output core_mask_t                   slot_avail,

  // Flush pulse and status readback
  input  core_mask_t                   slots_flush,
  output slot_count_t [CORE_COUNT-1:0] slot_counts
);

  // One busy bitmap per core
  slot_map_t [CORE_COUNT-1:0] busy_q;
  slot_map_t [CORE_COUNT-1:0] busy_next;
  logic                       rel_ready_q;
  logic                       rel_fire;

  // Releases are never refused once out of reset
  always_ff @(posedge clk) begin
    if (rst) begin
      rel_ready_q <= 1'b0;
    end else begin
      rel_ready_q <= 1'b1;
    end
  end

  assign rel_ready = rel_ready_q;
  assign rel_fire  = rel_valid && rel_ready_q;

  //////////////////////////////////////////////////////////////////////
  // Status

  // Lowest free slot of the selected core
  always_comb begin
    alloc_slot = '0;
    for (int s = SLOT_COUNT - 1; s >= 0; s--) begin
      if (!busy_q[selected_core][s]) begin
        alloc_slot = slot_id_t'(s);
      end
    end
  end

  for (genvar c = 0; c < CORE_COUNT; c++) begin : g_status
    // Core has room while any bit is clear
    assign slot_avail[c]  = ~&busy_q[c];
    assign slot_counts[c] = slot_count_t'($countones(busy_q[c]));
  end

  //////////////////////////////////////////////////////////////////////
  // Bitmap update

  always_comb begin
    busy_next = busy_q;
    // Release and pop on one core both apply, the popped slot was free
    if (rel_fire) begin
      busy_next[rel_core][rel_slot] = 1'b0;
    end
    if (desc_pop && slot_avail[selected_core]) begin
      busy_next[selected_core][alloc_slot] = 1'b1;
    end
    // Flush wins over everything on its cores
    for (int c = 0; c < CORE_COUNT; c++) begin
      if (slots_flush[c]) begin
        busy_next[c] = '0;
      end
    end
  end

  // All slots free after reset
  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= '0;
    end else begin
      busy_q <= busy_next;
    end
  end

endmodule

// File: rtl/lb_rr_policy.sv
/* Round-robin distribution policy */

module lb_rr_policy
  import lb_stream_pkg::*;
  import lb_slot_pkg::*;
(
  input  logic                         clk,
  input  logic                         rst,

  // Beats from the receive register
  input  data_word_t                   in_data,
  input  keep_t                        in_keep,
  input  logic                         in_last,
  input  logic                         in_valid,
  output logic                         in_ready,

  // Tagged beats toward the core register
  output core_beat_t                   out_beat,
  output logic                         out_valid,
  input  logic                         out_ready,

  // Registered host command port
  input  host_addr_t                   host_addr,
  input  logic                         host_wr_en,
  input  host_word_t                   host_wr_data,
  output host_word_t                   host_rd_data,

  // Config registers and slot status
  output core_mask_t                   enabled_cores,
  output core_mask_t                   slots_flush,
  input  core_mask_t                   slot_avail,
  input  slot_count_t [CORE_COUNT-1:0] slot_counts,

  // Request to the slot controller
  output core_id_t                     selected_core,
  output logic                         desc_pop,
  input  slot_id_t                     alloc_slot
);

  core_mask_t enable_q;
  core_mask_t flush_q;
  core_id_t   last_core_q;
  // Tag of the packet in flight
  tag_t       tag_q;
  logic       in_pkt_q;
  core_beat_t out_q;
  logic       out_valid_q;

  core_mask_t eligible;
  core_id_t   candidate;
  core_id_t   ring_idx;
  logic       found;
  logic       load;
  logic       accept;

  assign enabled_cores = enable_q;
  assign slots_flush   = flush_q;
  assign out_beat      = out_q;
  assign out_valid     = out_valid_q;

  //////////////////////////////////////////////////////////////////////
  // Core choice

  // Enabled and still holding a free slot
  assign eligible = enable_q & slot_avail;

  // First eligible core in ring order after the last one chosen
  always_comb begin
    candidate = last_core_q;
    found     = 1'b0;
    ring_idx  = last_core_q;
    for (int k = 1; k <= CORE_COUNT; k++) begin
      ring_idx = core_id_t'((int'(last_core_q) + k) % CORE_COUNT);
      if (!found && eligible[ring_idx]) begin
        candidate = ring_idx;
        found     = 1'b1;
      end
    end
  end

  // Later beats reuse the latched core
  assign selected_core = in_pkt_q ? tag_q.core : candidate;

  // Output register free, first beats also need a core with room
  assign load     = !out_valid_q || out_ready;
  assign in_ready = load && (in_pkt_q || found);
  assign accept   = in_valid && in_ready;
  // One pop per packet, with its first beat
  assign desc_pop = accept && !in_pkt_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      in_pkt_q    <= 1'b0;
      last_core_q <= core_id_t'(CORE_COUNT - 1);
      out_valid_q <= 1'b0;
    end else begin
      if (load) begin
        out_valid_q <= accept;
      end
      if (accept) begin
        in_pkt_q <= !in_last;
      end
      if (desc_pop) begin
        last_core_q <= candidate;
      end
    end
  end

  // Tag latch and output beat
  always_ff @(posedge clk) begin
    if (desc_pop) begin
      tag_q.core <= candidate;
      tag_q.slot <= alloc_slot;
    end
    if (accept) begin
      out_q.data <= in_data;
      out_q.keep <= in_keep;
      out_q.last <= in_last;
      out_q.dest <= selected_core;
      out_q.slot <= in_pkt_q ? tag_q.slot : alloc_slot;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Host registers

  always_ff @(posedge clk) begin
    if (rst) begin
      enable_q <= '1;
      flush_q  <= '0;
    end else begin
      // Flush is a one-cycle pulse
      flush_q <= '0;
      if (host_wr_en && host_addr == ADDR_ENABLE) begin
        enable_q <= host_wr_data[CORE_COUNT-1:0];
      end
      if (host_wr_en && host_addr == ADDR_FLUSH) begin
        flush_q <= host_wr_data[CORE_COUNT-1:0];
      end
    end
  end

  // Readback mux, registered again at the top
  always_comb begin
    host_rd_data = '0;
    if (host_addr == ADDR_ENABLE) begin
      host_rd_data[CORE_COUNT-1:0] = enable_q;
    end
    for (int i = 0; i < CORE_COUNT; i++) begin
      if (host_addr == host_addr_t'(ADDR_COUNT_BASE + i)) begin
        host_rd_data[$bits(slot_count_t)-1:0] = slot_counts[i];
      end
    end
  end

endmodule

// File: rtl/lb_top.sv
/* Load balancer top */

module lb_top
  import lb_stream_pkg::*;
  import lb_slot_pkg::*;
(
  input  logic       clk,
  input  logic       rst,

  // Receive stream
  input  data_word_t rx_data,
  input  keep_t      rx_keep,
  input  logic       rx_last,
  input  logic       rx_valid,
  output logic       rx_ready,

  // Stream toward the cores
  output data_word_t core_data,
  output keep_t      core_keep,
  output logic       core_last,
  output core_id_t   core_dest,
  output slot_id_t   core_slot,
  output logic       core_valid,
  input  logic       core_ready,

  // Data returned by the cores
  input  data_word_t ret_data,
  input  keep_t      ret_keep,
  input  logic       ret_last,
  input  logic       ret_valid,
  output logic       ret_ready,

  // Transmit stream
  output data_word_t tx_data,
  output keep_t      tx_keep,
  output logic       tx_last,
  output logic       tx_valid,
  input  logic       tx_ready,

  // Slot release from the cores
  input  slot_id_t   rel_slot,
  input  core_id_t   rel_core,
  input  logic       rel_valid,
  output logic       rel_ready,

  // Host command port
  input  host_addr_t host_addr,
  input  logic       host_wr_en,
  input  host_word_t host_wr_data,
  output host_word_t host_rd_data
);

  // Suffix _r follows an input register and _n feeds an output register
  logic                         rst_r;
  tx_beat_t                     rx_beat;
  tx_beat_t                     rx_beat_r;
  logic                         rx_valid_r;
  logic                         rx_ready_r;
  core_beat_t                   core_beat_n;
  logic                         core_valid_n;
  logic                         core_ready_n;
  core_beat_t                   core_beat;
  tx_beat_t                     ret_beat;
  tx_beat_t                     tx_beat;
  release_t                     rel_beat;
  release_t                     rel_beat_r;
  logic                         rel_valid_r;
  logic                         rel_ready_r;
  host_addr_t                   host_addr_r;
  host_word_t                   host_wr_data_r;
  logic                         host_wr_en_r;
  host_word_t                   host_rd_data_n;

  // Policy to slot controller
  core_mask_t                   slots_flush;
  core_mask_t                   slot_avail;
  slot_count_t [CORE_COUNT-1:0] slot_counts;
  core_id_t                     selected_core;
  logic                         desc_pop;
  slot_id_t                     alloc_slot;

  // Port bundling
  assign rx_beat  = '{data: rx_data, keep: rx_keep, last: rx_last};
  assign ret_beat = '{data: ret_data, keep: ret_keep, last: ret_last};
  assign rel_beat = '{core: rel_core, slot: rel_slot};

  assign core_data = core_beat.data;
  assign core_keep = core_beat.keep;
  assign core_last = core_beat.last;
  assign core_dest = core_beat.dest;
  assign core_slot = core_beat.slot;
  assign tx_data   = tx_beat.data;
  assign tx_keep   = tx_beat.keep;
  assign tx_last   = tx_beat.last;

  lb_sync_reset sync_rst_inst (.clk(clk), .rst(rst), .rst_sync(rst_r));

  //////////////////////////////////////////////////////////////////////
  // Boundary registers

  lb_boundary_reg #(.payload_t(tx_beat_t)) rx_reg_inst (
    .clk(clk), .rst(rst_r),
    .in_beat(rx_beat), .in_valid(rx_valid), .in_ready(rx_ready),
    .out_beat(rx_beat_r), .out_valid(rx_valid_r), .out_ready(rx_ready_r)
  );

  lb_boundary_reg #(.payload_t(core_beat_t)) core_reg_inst (
    .clk(clk), .rst(rst_r),
    .in_beat(core_beat_n), .in_valid(core_valid_n), .in_ready(core_ready_n),
    .out_beat(core_beat), .out_valid(core_valid), .out_ready(core_ready)
  );

  // Return path is forwarded unchanged to transmit
  lb_boundary_reg #(.payload_t(tx_beat_t)) tx_reg_inst (
    .clk(clk), .rst(rst_r),
    .in_beat(ret_beat), .in_valid(ret_valid), .in_ready(ret_ready),
    .out_beat(tx_beat), .out_valid(tx_valid), .out_ready(tx_ready)
  );

  lb_boundary_reg #(.payload_t(release_t)) rel_reg_inst (
    .clk(clk), .rst(rst_r),
    .in_beat(rel_beat), .in_valid(rel_valid), .in_ready(rel_ready),
    .out_beat(rel_beat_r), .out_valid(rel_valid_r), .out_ready(rel_ready_r)
  );

  // Host words load every cycle and the write strobe rides as valid
  lb_boundary_reg #(.payload_t(host_addr_t)) host_addr_reg_inst (
    .clk(clk), .rst(rst_r),
    .in_beat(host_addr), .in_valid(1'b1), .in_ready(),
    .out_beat(host_addr_r), .out_valid(), .out_ready(1'b1)
  );

  lb_boundary_reg #(.payload_t(host_word_t)) host_wr_reg_inst (
    .clk(clk), .rst(rst_r),
    .in_beat(host_wr_data), .in_valid(host_wr_en), .in_ready(),
    .out_beat(host_wr_data_r), .out_valid(host_wr_en_r), .out_ready(1'b1)
  );

  lb_boundary_reg #(.payload_t(host_word_t)) host_rd_reg_inst (
    .clk(clk), .rst(rst_r),
    .in_beat(host_rd_data_n), .in_valid(1'b1), .in_ready(),
    .out_beat(host_rd_data), .out_valid(), .out_ready(1'b1)
  );

  //////////////////////////////////////////////////////////////////////
  // Policy and slot controller

  lb_rr_policy lb_policy_inst (
    .clk(clk), .rst(rst_r),
    .in_data(rx_beat_r.data), .in_keep(rx_beat_r.keep), .in_last(rx_beat_r.last),
    .in_valid(rx_valid_r), .in_ready(rx_ready_r),
    .out_beat(core_beat_n), .out_valid(core_valid_n), .out_ready(core_ready_n),
    .host_addr(host_addr_r), .host_wr_en(host_wr_en_r),
    .host_wr_data(host_wr_data_r), .host_rd_data(host_rd_data_n),
    .enabled_cores(), .slots_flush(slots_flush),
    .slot_avail(slot_avail), .slot_counts(slot_counts),
    .selected_core(selected_core), .desc_pop(desc_pop), .alloc_slot(alloc_slot)
  );

  lb_slot_ctrl lb_slot_ctrl_inst (
    .clk(clk), .rst(rst_r),
    .rel_slot(rel_beat_r.slot), .rel_core(rel_beat_r.core),
    .rel_valid(rel_valid_r), .rel_ready(rel_ready_r),
    .selected_core(selected_core), .desc_pop(desc_pop), .alloc_slot(alloc_slot),
    .slot_avail(slot_avail), .slots_flush(slots_flush), .slot_counts(slot_counts)
  );

endmodule

// File: sim/tb_lb_top.sv
/* Load balancer testbench */

`include "lb_settings.svh"

module tb_lb_top
  import lb_stream_pkg::*;
  import lb_slot_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT  = 1000;
  localparam int HOLD_CYCLES = 40;

  logic       clk;
  logic       rst;
  data_word_t rx_data;
  keep_t      rx_keep;
  logic       rx_last;
  logic       rx_valid;
  logic       rx_ready;
  data_word_t core_data;
  keep_t      core_keep;
  logic       core_last;
  core_id_t   core_dest;
  slot_id_t   core_slot;
  logic       core_valid;
  logic       core_ready;
  data_word_t ret_data;
  keep_t      ret_keep;
  logic       ret_last;
  logic       ret_valid;
  logic       ret_ready;
  data_word_t tx_data;
  keep_t      tx_keep;
  logic       tx_last;
  logic       tx_valid;
  logic       tx_ready;
  slot_id_t   rel_slot;
  core_id_t   rel_core;
  logic       rel_valid;
  logic       rel_ready;
  host_addr_t host_addr;
  logic       host_wr_en;
  host_word_t host_wr_data;
  host_word_t host_rd_data;

  // Expected beats in arrival order
  core_beat_t exp_core_q[$];
  tx_beat_t   exp_tx_q[$];

  // Model copies of the enable mask, bitmaps and ring pointer
  core_mask_t model_enable;
  slot_map_t  model_busy [CORE_COUNT];
  int         model_last;
  // Packet held back while every enabled core is full
  logic       pend_valid;
  int         pend_len;
  data_word_t pend_first;
  int         tx_seq;

  lb_top lb_top_inst (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Error reporting and checks

  task automatic stop_run(input string line);
    $display("%s", line);
    $display("Checks failed");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic report_failure(input string what);
    stop_run($sformatf("ERROR at %0t: %s", $time, what));
  endtask

  task automatic report_mismatch(input string what);
    stop_run($sformatf("MISMATCH at %0t: %s", $time, what));
  endtask

  task automatic check_core_beat(input core_beat_t got, input core_beat_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf(
        "core beat %h/%h/%b dest %0d slot %0d, expected %h/%h/%b dest %0d slot %0d",
        got.data, got.keep, got.last, got.dest, got.slot,
        exp.data, exp.keep, exp.last, exp.dest, exp.slot));
    end
  endtask

  task automatic check_tx_beat(input tx_beat_t got, input tx_beat_t exp);
    if (got !== exp) begin
      report_mismatch($sformatf("tx beat %h/%h/%b, expected %h/%h/%b",
        got.data, got.keep, got.last, exp.data, exp.keep, exp.last));
    end
  endtask

  task automatic check_count(input slot_count_t got, input slot_count_t exp, input int core);
    if (got !== exp) begin
      report_mismatch($sformatf("core %0d slot count %0d, expected %0d", core, got, exp));
    end
  endtask

  task automatic check_host_word(input host_word_t got, input host_word_t exp,
                                 input host_addr_t addr);
    if (got !== exp) begin
      report_mismatch($sformatf("host read at %h gave %h, expected %h", addr, got, exp));
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Distribution model

  // Next enabled core with room in ring order or -1 when none
  function automatic int next_core();
    int c;
    next_core = -1;
    for (int k = CORE_COUNT; k >= 1; k--) begin
      c = (model_last + k) % CORE_COUNT;
      if (model_enable[c] && model_busy[c] != '1) begin
        next_core = c;
      end
    end
  endfunction

  // Scan upward from slot 0
  function automatic int lowest_free(input int c);
    for (int s = 0; s < SLOT_COUNT; s++) begin
      if (!model_busy[c][s]) begin
        return s;
      end
    end
    return 0;
  endfunction

  task automatic take_slot(output core_id_t core, output slot_id_t slot);
    int c;
    int s;
    c = next_core();
    s = lowest_free(c);
    model_busy[c][s] = 1'b1;
    model_last = c;
    core = core_id_t'(c);
    slot = slot_id_t'(s);
  endtask

  // Last beat of a packet carries a partial word
  function automatic keep_t beat_keep(input int idx, input int len);
    if (idx == len - 1) begin
      beat_keep = keep_t'((1 << (`LB_KEEP_WIDTH / 2)) - 1);
    end else begin
      beat_keep = '1;
    end
  endfunction

  task automatic push_core_beats(input int len, input data_word_t first,
                                 input core_id_t core, input slot_id_t slot);
    core_beat_t beat;
    for (int i = 0; i < len; i++) begin
      beat.data = first + data_word_t'(i);
      beat.keep = beat_keep(i, len);
      beat.last = (i == len - 1);
      beat.dest = core;
      beat.slot = slot;
      exp_core_q.push_back(beat);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Waits

  function automatic logic port_ready(input int port);
    case (port)
      0:       port_ready = rx_ready;
      1:       port_ready = ret_ready;
      default: port_ready = rel_ready;
    endcase
  endfunction

  // Returns on the edge where the beat moved
  task automatic wait_accept(input int port, input string name);
    int waited;
    waited = 0;
    @(posedge clk);
    while (port_ready(port) !== 1'b1) begin
      if (waited == WAIT_LIMIT) begin
        report_failure({"timed out waiting for ", name});
      end
      waited++;
      @(posedge clk);
    end
  endtask

  task automatic drain_expected(input logic tx_side);
    int waited;
    waited = 0;
    while ((tx_side ? exp_tx_q.size() : exp_core_q.size()) != 0) begin
      if (waited == WAIT_LIMIT) begin
        report_failure(tx_side ? "timed out waiting for words on the transmit stream"
                               : "timed out waiting for a packet on the core stream");
      end
      waited++;
      @(posedge clk);
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Operations

  task automatic send_packet(input int len, input data_word_t first);
    core_id_t core;
    slot_id_t slot;
    logic     held;
    held = (next_core() < 0);
    if (!held) begin
      take_slot(core, slot);
      push_core_beats(len, first, core, slot);
    end
    for (int i = 0; i < len; i++) begin
      rx_data  <= first + data_word_t'(i);
      rx_keep  <= beat_keep(i, len);
      rx_last  <= (i == len - 1);
      rx_valid <= 1'b1;
      wait_accept(0, "rx_ready");
    end
    rx_valid <= 1'b0;
    if (held) begin
      pend_valid = 1'b1;
      pend_len   = len;
      pend_first = first;
      // Nothing may leave while no enabled core has room
      for (int n = 0; n < HOLD_CYCLES; n++) begin
        @(posedge clk);
        if (core_valid) begin
          report_failure("a beat left on the core stream while every enabled core was full");
        end
      end
    end else begin
      drain_expected(1'b0);
    end
  endtask

  task automatic release_slot(input core_id_t core, input slot_id_t slot);
    core_id_t pend_core;
    slot_id_t pend_slot;
    rel_core  <= core;
    rel_slot  <= slot;
    rel_valid <= 1'b1;
    wait_accept(2, "rel_ready");
    rel_valid <= 1'b0;
    model_busy[core][slot] = 1'b0;
    if (pend_valid && next_core() >= 0) begin
      // Held packet goes out with the freed slot
      take_slot(pend_core, pend_slot);
      push_core_beats(pend_len, pend_first, pend_core, pend_slot);
      pend_valid = 1'b0;
      drain_expected(1'b0);
    end else begin
      // Release lands one cycle after the input register
      repeat (3) @(posedge clk);
    end
  endtask

  task automatic host_write(input host_addr_t addr, input host_word_t data);
    host_addr    <= addr;
    host_wr_data <= data;
    host_wr_en   <= 1'b1;
    @(posedge clk);
    host_wr_en <= 1'b0;
    // A flush reaches the bitmaps one cycle after the register update
    repeat (3) @(posedge clk);
    if (addr == ADDR_ENABLE) begin
      model_enable = data[CORE_COUNT-1:0];
    end
    if (addr == ADDR_FLUSH) begin
      for (int c = 0; c < CORE_COUNT; c++) begin
        if (data[c]) begin
          model_busy[c] = '0;
        end
      end
    end
  endtask

  task automatic host_read(input host_addr_t addr, input host_word_t exp);
    int core;
    host_addr <= addr;
    // Address register and then readback register
    repeat (3) @(posedge clk);
    check_host_word(host_rd_data, exp, addr);
    core = int'(addr) - int'(ADDR_COUNT_BASE);
    if (core >= 0 && core < CORE_COUNT) begin
      check_count(slot_count_t'(host_rd_data),
                  slot_count_t'($countones(model_busy[core])), core);
    end
  endtask

  task automatic forward_words(input int count);
    tx_beat_t word;
    for (int i = 0; i < count; i++) begin
      word.data = data_word_t'({32'h7A00_0000 + tx_seq, ~tx_seq});
      word.keep = beat_keep(i, count);
      word.last = (i == count - 1);
      exp_tx_q.push_back(word);
      ret_data  <= word.data;
      ret_keep  <= word.keep;
      ret_last  <= word.last;
      ret_valid <= 1'b1;
      wait_accept(1, "ret_ready");
      tx_seq++;
    end
    ret_valid <= 1'b0;
    drain_expected(1'b1);
  endtask

  //////////////////////////////////////////////////////////////////////
  // Output monitors and random ready gaps

  initial begin
    core_beat_t got_core;
    tx_beat_t   got_tx;
    int         seed_word;
    core_ready <= 1'b0;
    tx_ready   <= 1'b0;
    seed_word = $urandom(6);
    forever begin
      @(posedge clk);
      if (!rst && core_valid && core_ready) begin
        got_core.data = core_data;
        got_core.keep = core_keep;
        got_core.last = core_last;
        got_core.dest = core_dest;
        got_core.slot = core_slot;
        if (exp_core_q.size() == 0) begin
          report_failure("a beat arrived on the core stream with no packet expected");
        end else begin
          check_core_beat(got_core, exp_core_q.pop_front());
        end
      end
      if (!rst && tx_valid && tx_ready) begin
        got_tx.data = tx_data;
        got_tx.keep = tx_keep;
        got_tx.last = tx_last;
        if (exp_tx_q.size() == 0) begin
          report_failure("a word arrived on the transmit stream with none expected");
        end else begin
          check_tx_beat(got_tx, exp_tx_q.pop_front());
        end
      end
      core_ready <= ($urandom % 4) != 0;
      tx_ready   <= ($urandom % 3) != 0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Case file runner

  initial begin
    int                fd;
    int                fields;
    logic [8*160-1:0]  line_buf;
    logic [8*8-1:0]    op_word;
    data_word_t        arg_a;
    data_word_t        arg_b;
    rst          <= 1'b1;
    rx_data      <= '0;
    rx_keep      <= '0;
    rx_last      <= 1'b0;
    rx_valid     <= 1'b0;
    ret_data     <= '0;
    ret_keep     <= '0;
    ret_last     <= 1'b0;
    ret_valid    <= 1'b0;
    rel_slot     <= '0;
    rel_core     <= '0;
    rel_valid    <= 1'b0;
    host_addr    <= '0;
    host_wr_en   <= 1'b0;
    host_wr_data <= '0;
    model_enable = '1;
    for (int c = 0; c < CORE_COUNT; c++) begin
      model_busy[c] = '0;
    end
    model_last = CORE_COUNT - 1;
    pend_valid = 1'b0;
    tx_seq     = 0;
    fd = $fopen("sim/lb_cases.txt", "r");
    if (fd == 0) begin
      report_failure("could not open sim/lb_cases.txt");
    end
    repeat (8) @(posedge clk);
    rst <= 1'b0;
    // Internal reset trails by two cycles
    repeat (4) @(posedge clk);
    while ($fgets(line_buf, fd) != 0) begin
      fields = $sscanf(line_buf, "%s %h %h", op_word, arg_a, arg_b);
      if (fields >= 1) begin
        case (op_word)
          "SEND":    send_packet(int'(arg_a), arg_b);
          "RELEASE": release_slot(core_id_t'(arg_a), slot_id_t'(arg_b));
          "HOSTWR":  host_write(host_addr_t'(arg_a), host_word_t'(arg_b));
          "HOSTRD":  host_read(host_addr_t'(arg_a), host_word_t'(arg_b));
          "TXFWD":   forward_words(int'(arg_a));
          "STALL":   repeat (int'(arg_a)) @(posedge clk);
          "#":       ;
          default:   report_failure("unknown operation in the cases file");
        endcase
      end
    end
    $fclose(fd);
    if (pend_valid) begin
      report_failure("a held packet was never released");
    end else begin
      $display("All checks passed");
      $finish;
    end
  end

endmodule

// File: lb_top.f
+incdir+include
rtl/lb_slot_pkg.sv
rtl/lb_stream_pkg.sv
rtl/lb_sync_reset.sv
rtl/lb_boundary_reg.sv
rtl/lb_slot_ctrl.sv
rtl/lb_rr_policy.sv
rtl/lb_top.sv
sim/tb_lb_top.sv

// File: Bender.yml
package:
  name: lb_top

sources:
  # Slot types come first, the stream types import them
  - include_dirs:
      - include
    files:
      - rtl/lb_slot_pkg.sv
      - rtl/lb_stream_pkg.sv
      - rtl/lb_sync_reset.sv
      - rtl/lb_boundary_reg.sv
      - rtl/lb_slot_ctrl.sv
      - rtl/lb_rr_policy.sv
      - rtl/lb_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - sim/tb_lb_top.sv

// File: sim/lb_cases.txt
# Load balancer cases, every number in hex
# SEND len first_word | RELEASE core slot | HOSTWR addr data | HOSTRD addr expected
# TXFWD words | STALL cycles
# Round robin over all cores, lowest free slot each
SEND 3 1000
SEND 1 2000
SEND 2 3000
SEND 4 4000
SEND 2 5000
HOSTRD 04 2
RELEASE 0 0
HOSTRD 04 1
SEND 1 6000
# Only cores 0 and 2 enabled
HOSTWR 00 5
HOSTRD 00 5
SEND 2 7000
SEND 1 8000
SEND 1 9000
HOSTWR 00 f
SEND 1 a000
SEND 1 b000
TXFWD 8
# Core 0 alone fills up, then a packet is held
HOSTWR 00 1
SEND 2 c000
SEND 1 d000
RELEASE 0 1
HOSTWR 00 f
SEND 1 e000
SEND 2 f000
SEND 1 10000
SEND 3 11000
HOSTRD 04 4
HOSTRD 05 4
HOSTRD 06 4
HOSTRD 07 3
# Flush cores 0 and 1
HOSTWR 01 3
HOSTRD 04 0
HOSTRD 05 0
HOSTRD 06 4
SEND 1 12000
SEND 2 13000
HOSTRD 07 4
HOSTRD 04 1
STALL 5
TXFWD 5
HOSTRD 00 f
